/* all.f */
source/atc_pkg.sv
source/sync_fifo.sv
source/runway_tracker.sv
source/request_interpreter.sv
source/reply_sender.sv
source/atc_top.sv
verif/atc_tb.sv

/* verif/atc_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the tower controller
// Clock, reset, stimulus, reference model, reply monitor,
// watchdog and summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_tb
  import atc_pkg::*;
;

  localparam int clock_period    = 10;
  localparam int aircraft_depth  = 4;
  localparam int test_count      = 6;
  localparam int cycles_per_test = 2000;

  logic         clock;
  logic         reset;
  message_t     message_in;
  logic         message_valid;
  logic         busy;
  message_t     message_out;
  logic         message_send;
  logic         ready_to_send;
  runway_mask_t runway_active;

  // Reference state
  plane_id_t    takeoff_model[$];
  plane_id_t    landing_model[$];
  plane_id_t    model_owner [runway_count];
  runway_mask_t model_active;
  logic         model_landing_turn;
  message_t     expected[$];

  int           errors;
  int           checks;
  logic         hold_line;

  atc_top #(
    .request_depth(4),
    .aircraft_depth(aircraft_depth),
    .reply_depth(4)
  ) i_atc_top (
    .clock(clock),
    .reset(reset),
    .message_in(message_in),
    .message_valid(message_valid),
    .busy(busy),
    .message_out(message_out),
    .message_send(message_send),
    .ready_to_send(ready_to_send),
    .runway_active(runway_active)
  );

  always #(clock_period / 2) clock = !clock;

  //////////////////////////////////////////////////////////////////////
  // Reference model and checking
  //////////////////////////////////////////////////////////////////////

  // Expected replies for one message, then any clearances it allows
  function automatic void model_message(input message_t msg);
    plane_id_t   id;
    msg_type_t   kind;
    msg_action_t action;
    plane_id_t   next_id;
    logic        runway;
    logic        use_landing;
    {id, kind, action} = msg;
    if (kind == type_request) begin
      if (action[1] ? (landing_model.size() >= aircraft_depth)
                    : (takeoff_model.size() >= aircraft_depth)) begin
        expected.push_back({id, type_divert, 2'b00});
      end else begin
        if (action[1]) landing_model.push_back(id);
        else takeoff_model.push_back(id);
        expected.push_back({id, type_hold, 2'b00});
      end
    end else if (kind == type_declare) begin
      if (model_active[action[0]] && (model_owner[action[0]] == id))
        model_active[action[0]] = 1'b0;
    end else begin
      expected.push_back({id, type_say_again, 2'b00});
    end
    while ((model_active != 2'b11) &&
           ((landing_model.size() != 0) || (takeoff_model.size() != 0))) begin
      use_landing = (landing_model.size() != 0) &&
                    ((takeoff_model.size() == 0) || model_landing_turn);
      if (use_landing) next_id = landing_model.pop_front();
      else next_id = takeoff_model.pop_front();
      // Runway 0 first
      if (!model_active[0]) runway = 1'b0;
      else runway = 1'b1;
      model_active[runway] = 1'b1;
      model_owner[runway]  = next_id;
      model_landing_turn   = !model_landing_turn;
      expected.push_back({next_id, type_clear, {1'b0, runway}});
    end
  endfunction

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] wanted);
    checks++;
    if (actual !== wanted) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, actual, wanted);
    end
  endtask

  // Sampled mid-cycle where outputs are settled
  always @(negedge clock) begin
    if (!reset && message_send) begin
      if (hold_line) begin
        errors++;
        $display("Message sent while ready_to_send was low");
      end
      if (expected.size() == 0) begin
        errors++;
        $display("Message %h sent with no reply expected", message_out);
      end else begin
        check_value("message_out", message_out, expected.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    takeoff_model.delete();
    landing_model.delete();
    expected.delete();
    model_active       = '0;
    model_landing_turn = 1'b1;
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic send_message(input message_t msg);
    // A strobe while the request queue is full would be dropped
    while (busy) begin
      @(posedge clock);
      #1;
    end
    message_in    = msg;
    message_valid = 1'b1;
    model_message(msg);
    @(posedge clock);
    #1;
    message_valid = 1'b0;
  endtask

  // All expected replies out and the outputs idle for a while
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while ((expected.size() != 0) || (quiet < 8)) begin
      @(negedge clock);
      if (message_send || (expected.size() != 0)) quiet = 0;
      else quiet++;
    end
    @(posedge clock);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scenarios
  //////////////////////////////////////////////////////////////////////

  initial begin
    plane_id_t id;
    message_t  msg;
    logic      runway_pick;
    int        sent;
    void'($urandom(32'h637e));
    clock         = 1'b0;
    reset         = 1'b1;
    message_in    = '0;
    message_valid = 1'b0;
    ready_to_send = 1'b1;
    hold_line     = 1'b0;
    errors        = 0;
    checks        = 0;
    apply_reset();

    // Idle after reset
    check_value("runway_active", runway_active, 2'b00);
    check_value("busy", busy, 1'b0);
    check_value("message_send", message_send, 1'b0);
    repeat (20) @(posedge clock);
    #1;

    // Unknown type and the emergency code
    send_message({plane_id_t'($urandom), 3'b110, 2'b11});
    send_message({plane_id_t'($urandom), 3'b010, 2'b01});
    wait_quiet();

    // Three takeoffs fill both runways
    repeat (3) send_message({plane_id_t'($urandom), type_request, 2'b00});
    wait_quiet();
    check_value("runway_active", runway_active, 2'b11);

    // Declare from a stranger, then from the owner of runway 0
    do id = plane_id_t'($urandom); while (id == model_owner[0]);
    send_message({id, type_declare, 2'b00});
    wait_quiet();
    check_value("runway_active", runway_active, 2'b11);
    send_message({model_owner[0], type_declare, 2'b00});
    wait_quiet();
    check_value("runway_active", runway_active, model_active);

    // Full landing queue, then alternating clearances
    apply_reset();
    repeat (2) send_message({plane_id_t'($urandom), type_request, 2'b00});
    repeat (5) send_message({plane_id_t'($urandom), type_request, 2'b10});
    repeat (2) send_message({plane_id_t'($urandom), type_request, 2'b00});
    wait_quiet();
    check_value("runway_active", runway_active, 2'b11);
    runway_pick = 1'b0;
    while ((landing_model.size() + takeoff_model.size()) != 0) begin
      send_message({model_owner[runway_pick], type_declare, {1'b0, runway_pick}});
      wait_quiet();
      runway_pick = !runway_pick;
    end

    // Line held low until the request queue backs up
    ready_to_send = 1'b0;
    hold_line     = 1'b1;
    sent          = 0;
    while (!busy && (sent < 24)) begin
      if ($urandom_range(0, 3) == 0) msg = {plane_id_t'($urandom), 3'b110, 2'b00};
      else msg = {plane_id_t'($urandom), type_request, 2'($urandom)};
      send_message(msg);
      sent++;
    end
    if (!busy) begin
      errors++;
      $display("busy did not rise while the line was held low");
    end
    repeat ($urandom_range(5, 20)) @(posedge clock);
    #1;
    ready_to_send = 1'b1;
    hold_line     = 1'b0;
    wait_quiet();
    check_value("runway_active", runway_active, model_active);

    $display("Summary: %0d checks, %0d errors, %0d replies outstanding",
             checks, errors, expected.size());
    if ((errors == 0) && (expected.size() == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(test_count * cycles_per_test * clock_period);
    $display("Run timed out waiting for replies, %0d errors so far", errors);
    $display("tests failed");
    $finish;
  end

endmodule : atc_tb

/* source/atc_top.sv */
//////////////////////////////////////////////////////////////////////
// Tower controller top level
// Request queue, request interpreter and reply sender in a chain
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module atc_top
  import atc_pkg::*;
#(
  parameter int request_depth  = 4,
  parameter int aircraft_depth = 4,
  parameter int reply_depth    = 4
) (
  input  logic         clock,
  input  logic         reset,
  input  message_t     message_in,
  input  logic         message_valid,
  output logic         busy,
  output message_t     message_out,
  output logic         message_send,
  input  logic         ready_to_send,
  output runway_mask_t runway_active
);

  // Request queue to interpreter
  message_t request_word;
  logic     request_read;
  logic     request_empty;

  // Interpreter to reply sender
  message_t reply_word;
  logic     reply_write;
  logic     reply_full;

  // Strobes arriving while full are dropped by the queue
  sync_fifo #(.width(message_width), .depth(request_depth)) request_queue (
    .clock(clock),
    .reset(reset),
    .write(message_valid),
    .read(request_read),
    .data_in(message_in),
    .data_out(request_word),
    .full(busy),
    .empty(request_empty)
  );

  request_interpreter #(.aircraft_depth(aircraft_depth)) interpreter (
    .clock(clock),
    .reset(reset),
    .request_word(request_word),
    .request_empty(request_empty),
    .request_read(request_read),
    .reply_full(reply_full),
    .reply_word(reply_word),
    .reply_write(reply_write),
    .runway_active(runway_active)
  );

  reply_sender #(.reply_depth(reply_depth)) sender (
    .clock(clock),
    .reset(reset),
    .reply_write(reply_write),
    .ready_to_send(ready_to_send),
    .reply_word(reply_word),
    .reply_full(reply_full),
    .message_out(message_out),
    .message_send(message_send)
  );

endmodule : atc_top

/* source/reply_sender.sv */
//////////////////////////////////////////////////////////////////////
// Reply sender
// Reply FIFO and the transmit sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reply_sender
  import atc_pkg::*;
#(
  parameter int reply_depth = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     reply_write,
  input  logic     ready_to_send,
  input  message_t reply_word,
  output logic     reply_full,
  output message_t message_out,
  output logic     message_send
);

  typedef enum logic {
    waiting,
    sending
  } state_t;

  state_t state;
  state_t next_state;
  logic   pop;
  logic   queue_empty;

  //////////////////////////////////////////////////////////////////////
  // Reply queue
  //////////////////////////////////////////////////////////////////////

  // Registered read port holds message_out between sends
  sync_fifo #(.width(message_width), .depth(reply_depth)) reply_queue (
    .clock(clock),
    .reset(reset),
    .write(reply_write),
    .read(pop),
    .data_in(reply_word),
    .data_out(message_out),
    .full(reply_full),
    .empty(queue_empty)
  );

  //////////////////////////////////////////////////////////////////////
  // Transmit sequencer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state   = state;
    pop          = 1'b0;
    message_send = 1'b0;
    case (state)
      waiting: begin
        if (ready_to_send && !queue_empty) begin
          pop        = 1'b1;
          next_state = sending;
        end
      end
      sending: begin
        // Popped word is on message_out now
        message_send = 1'b1;
        next_state   = waiting;
      end
      default: next_state = waiting;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) state <= waiting;
    else       state <= next_state;
  end

endmodule : reply_sender

/* source/request_interpreter.sv */
//////////////////////////////////////////////////////////////////////
// Request interpreter
// Request FSM, takeoff and landing queues, runway tracker
// and the reply register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_interpreter
  import atc_pkg::*;
#(
  parameter int aircraft_depth = 4
) (
  input  logic         clock,
  input  logic         reset,
  input  message_t     request_word,
  input  logic         request_empty,
  output logic         request_read,
  input  logic         reply_full,
  output message_t     reply_word,
  output logic         reply_write,
  output runway_mask_t runway_active
);

  typedef enum logic [2:0] {
    idle,
    interpret,
    queue_reply,
    check_queues,
    clear_plane,
    queue_clear
  } state_t;

  state_t      state;
  state_t      next_state;

  // Request fields
  plane_id_t   request_plane;
  msg_type_t   request_type;
  msg_action_t request_action;

  logic        takeoff_write, takeoff_read, takeoff_full, takeoff_empty;
  logic        landing_write, landing_read, landing_full, landing_empty;
  plane_id_t   takeoff_plane, landing_plane;
  plane_id_t   cleared_plane, tracker_plane;
  logic        lock, unlock, tracker_runway;

  // Alternation between queues, landing first after reset
  logic        landing_turn;
  logic        from_landing;

  logic        load_reply;
  message_t    next_reply;

  assign {request_plane, request_type, request_action} = request_word;

  assign cleared_plane = from_landing ? landing_plane : takeoff_plane;
  assign tracker_plane = (state == clear_plane) ? cleared_plane : request_plane;

  //////////////////////////////////////////////////////////////////////
  // Aircraft queues and runway tracker
  //////////////////////////////////////////////////////////////////////

  sync_fifo #(.width($bits(plane_id_t)), .depth(aircraft_depth)) takeoff_queue (
    .clock(clock), .reset(reset),
    .write(takeoff_write), .read(takeoff_read),
    .data_in(request_plane), .data_out(takeoff_plane),
    .full(takeoff_full), .empty(takeoff_empty)
  );

  sync_fifo #(.width($bits(plane_id_t)), .depth(aircraft_depth)) landing_queue (
    .clock(clock), .reset(reset),
    .write(landing_write), .read(landing_read),
    .data_in(request_plane), .data_out(landing_plane),
    .full(landing_full), .empty(landing_empty)
  );

  runway_tracker tracker (
    .clock(clock), .reset(reset),
    .lock(lock), .unlock(unlock),
    .runway(tracker_runway), .plane_id(tracker_plane),
    .runway_active(runway_active)
  );

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state     = state;
    request_read   = 1'b0;
    takeoff_write  = 1'b0;
    takeoff_read   = 1'b0;
    landing_write  = 1'b0;
    landing_read   = 1'b0;
    lock           = 1'b0;
    unlock         = 1'b0;
    tracker_runway = request_action[0];
    reply_write    = 1'b0;
    load_reply     = 1'b0;
    next_reply     = '0;
    case (state)
      idle: begin
        if (!request_empty) begin
          request_read = 1'b1;
          next_state   = interpret;
        end
      end
      interpret: begin
        next_state = queue_reply;
        load_reply = 1'b1;
        next_reply = {request_plane, type_say_again, 2'b00};
        if (request_type == type_request) begin
          // Action bit 1 selects landing over takeoff
          if (request_action[1] ? landing_full : takeoff_full) begin
            next_reply = {request_plane, type_divert, 2'b00};
          end else begin
            landing_write = request_action[1];
            takeoff_write = !request_action[1];
            next_reply    = {request_plane, type_hold, 2'b00};
          end
        end else if (request_type == type_declare) begin
          // No reply, the release may open a runway
          load_reply = 1'b0;
          unlock     = 1'b1;
          next_state = check_queues;
        end
      end
      queue_reply: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state  = check_queues;
        end
      end
      check_queues: begin
        next_state = idle;
        if (runway_active != {runway_count{1'b1}}) begin
          if (!landing_empty && (takeoff_empty || landing_turn)) begin
            landing_read = 1'b1;
            next_state   = clear_plane;
          end else if (!takeoff_empty) begin
            takeoff_read = 1'b1;
            next_state   = clear_plane;
          end
        end
      end
      clear_plane: begin
        // Runway 0 unless it is taken
        tracker_runway = runway_active[0];
        lock           = 1'b1;
        load_reply     = 1'b1;
        next_reply     = {cleared_plane, type_clear, {1'b0, tracker_runway}};
        next_state     = queue_clear;
      end
      queue_clear: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state  = check_queues;
        end
      end
      default: next_state = idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= idle;
      landing_turn <= 1'b1;
      from_landing <= 1'b0;
    end else begin
      state <= next_state;
      if (lock) landing_turn <= !landing_turn;
      if (takeoff_read || landing_read) from_landing <= landing_read;
    end
  end

  always_ff @(posedge clock) begin
    if (load_reply) reply_word <= next_reply;
  end

  // check_queues only dequeues while a runway is free
  lock_free_runway: assert property (
    @(posedge clock) disable iff (reset) lock |-> !runway_active[tracker_runway]
  );

endmodule : request_interpreter

/* source/runway_tracker.sv */
//////////////////////////////////////////////////////////////////////
// Runway tracker
// Active flag and owner id per runway, lock and owner-checked unlock
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module runway_tracker
  import atc_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         lock,
  input  logic         unlock,
  input  logic         runway,
  input  plane_id_t    plane_id,
  output runway_mask_t runway_active
);

  runway_mask_t active;
  plane_id_t    owner [runway_count];

  assign runway_active = active;

  //////////////////////////////////////////////////////////////////////
  // Active flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= '0;
    end else if (lock) begin
      active[runway] <= 1'b1;
    end else if (unlock && (plane_id == owner[runway])) begin
      // Only the plane holding the runway may release it
      active[runway] <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Owner ids
  //////////////////////////////////////////////////////////////////////

  // Owner is recorded alongside the lock
  always_ff @(posedge clock) begin
    if (lock) begin
      owner[runway] <= plane_id;
    end
  end

  // Interpreter issues a lock and an unlock from different states
  lock_unlock_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(lock && unlock)
  );

endmodule : runway_tracker

/* source/sync_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Synchronous FIFO with a registered read port
// Circular buffer with an occupancy count, full and empty flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo
  import atc_pkg::*;
#(
  parameter int width = message_width,
  parameter int depth = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             write,
  input  logic             read,
  input  logic [width-1:0] data_in,
  output logic [width-1:0] data_out,
  output logic             full,
  output logic             empty
);

  localparam int pointer_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width   = $clog2(depth + 1);

  logic [width-1:0]         memory [depth];
  logic [pointer_width-1:0] write_pointer;
  logic [pointer_width-1:0] read_pointer;
  logic [count_width-1:0]   count;
  logic                     do_write;
  logic                     do_read;

  // Wrap at depth, which need not be a power of two
  function automatic logic [pointer_width-1:0] next_pointer(
    input logic [pointer_width-1:0] pointer
  );
    return (pointer == pointer_width'(depth - 1)) ? '0 : pointer + 1'b1;
  endfunction

  assign empty    = (count == 0);
  assign full     = (count == count_width'(depth));
  assign do_read  = read && !empty;
  // A read in the same cycle frees the slot for a write when full
  assign do_write = write && (!full || do_read);

  always_ff @(posedge clock) begin
    if (reset) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      count         <= '0;
    end else begin
      if (do_write) write_pointer <= next_pointer(write_pointer);
      if (do_read)  read_pointer  <= next_pointer(read_pointer);
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge clock) begin
    if (do_write) memory[write_pointer] <= data_in;
    if (do_read)  data_out <= memory[read_pointer];
  end

  count_within_depth: assert property (
    @(posedge clock) disable iff (reset) count <= count_width'(depth)
  );

endmodule : sync_fifo

/* source/atc_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared definitions for the airfield tower controller
// Message field types, reply and request type codes, runway constants
//////////////////////////////////////////////////////////////////////

package atc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////////////////////////

  // Message layout is {plane id, type, action}, msb first
  localparam int message_width = 9;

  // Two runways, fixed by the design
  localparam int runway_count = 2;

  //////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////

  typedef logic [message_width-1:0] message_t;
  typedef logic [3:0]               plane_id_t;
  typedef logic [2:0]               msg_type_t;
  typedef logic [1:0]               msg_action_t;

  // One active flag per runway
  typedef logic [runway_count-1:0]  runway_mask_t;

  //////////////////////////////////////////////////////////////////////
  // Type codes
  //////////////////////////////////////////////////////////////////////

  // Inbound
  localparam msg_type_t type_request    = 3'b000;
  localparam msg_type_t type_declare    = 3'b001;

  // Outbound replies
  localparam msg_type_t type_clear      = 3'b100;
  localparam msg_type_t type_hold       = 3'b101;
  localparam msg_type_t type_say_again  = 3'b110;
  localparam msg_type_t type_divert     = 3'b111;

endpackage : atc_pkg
